/* hw/mic_macros.svh */
// Sequencer size parameters
//   Microcode address and microword widths
//   Return stack depth
//   Consumer credit count
`ifndef MIC_MACROS_SVH
`define MIC_MACROS_SVH

// Microcode address width, 8K word control store
`define MIC_ADDR_W 13

// Microword width
// Select, format bit and payload
`define MIC_WORD_W 24

// Return stack entries
// Deepest call nesting before overflow
`define MIC_STACK_DEPTH 8

// Issue credits held by the sequencer
// Matches the consumer input buffer depth
`define MIC_CREDITS 4

// Jump target low nibble comes from the jmp input
// Address must stay wider than that nibble
// Microword must hold select, format, call and the jump high part
// Operation payload is whatever is left after select and format

`endif

/* hw/mic_seq_pkg.sv */
// Sequencer types
//   Microcode address type
//   Next address source encoding
//   Issue item sent to the execution consumer
`include "mic_macros.svh"

package mic_seq_pkg;

  // Microcode address, W and IW registers and stack entries
  typedef logic [`MIC_ADDR_W-1:0] mic_addr_t;

  // Next address source
  // Same order as the original four way mux inputs
  typedef enum logic [1:0] {
    src_jump   = 2'd0,  // Branch high field joined with jmp
    src_ret    = 2'd1,  // Return stack top, popped
    src_next   = 2'd2,  // W plus 1
    src_repeat = 2'd3   // IW
  } addr_src_e;

  // One issued microinstruction
  // Address first so the consumer sees it in the high bits
  typedef struct packed {
    mic_addr_t              addr;  // W at the step
    logic [`MIC_WORD_W-1:0] word;  // Microword read at W
  } issue_s;

  // Consumer decodes word with the microword format package
  // Address is kept for trace and debug

endpackage

/* hw/cs_format_pkg.sv */
// Control store microword format
//   Format bit encoding
//   Branch view and operation view
//   Union of both views over one microword
`include "mic_macros.svh"

package cs_format_pkg;

  // Format bit just below the source select
  typedef enum logic {
    fmt_op     = 1'b0,  // Plain operation for the consumer
    fmt_branch = 1'b1   // Branch word, may call
  } fmt_e;

  // Branch view
  // Jump target bits 12..4 here, bits 3..0 from jmp
  typedef struct packed {
    mic_seq_pkg::addr_src_e           sel;      // Next address source
    fmt_e                             fmt;
    logic                             call;     // Push W plus 1
    logic [`MIC_ADDR_W-5:0]           jump_hi;  // Target high part
    logic [`MIC_WORD_W-`MIC_ADDR_W-1:0] rsvd;   // Unused, keep zero
  } branch_s;

  // Operation view
  // Control field is opaque to the sequencer
  typedef struct packed {
    mic_seq_pkg::addr_src_e sel;
    fmt_e                   fmt;
    logic [`MIC_WORD_W-4:0] ctrl;  // Handed to the consumer as is
  } op_s;

  // One microword, two decodings
  // sel and fmt line up in both views
  typedef union packed {
    branch_s br;
    op_s     op;
  } mic_word_u;

endpackage

/* hw/mic_addr_select.sv */
// Next microcode address select
//   Four way source mux, jump / return / next / repeat
//   Incrementer for the next address
//   W and IW address registers with step hold

module mic_addr_select (
  input  logic                   sysclk,
  input  logic                   sys_rst_n,
  input  logic                   step,       // Advance one microinstruction
  input  mic_seq_pkg::addr_src_e src,        // Select field of the issued word
  input  mic_seq_pkg::mic_addr_t jump_addr,  // Branch target with jmp nibble
  input  mic_seq_pkg::mic_addr_t ret_addr,   // Return stack top
  output mic_seq_pkg::mic_addr_t w,          // Working address
  output mic_seq_pkg::mic_addr_t iw,         // Address of the last issue
  output mic_seq_pkg::mic_addr_t next_addr   // W plus 1
);

  mic_seq_pkg::mic_addr_t sel_addr;  // Mux output, loaded into W

  // Incrementer
  // Wraps at the top of the store
  assign next_addr = w + 1'b1;

  // Source mux
  always_comb begin
    unique case (src)
      mic_seq_pkg::src_jump:   sel_addr = jump_addr;
      mic_seq_pkg::src_ret:    sel_addr = ret_addr;
      mic_seq_pkg::src_next:   sel_addr = next_addr;
      mic_seq_pkg::src_repeat: sel_addr = iw;  // Back to previous issue
    endcase
  end

  // W and IW registers
  // Both hold while there is no step
  always_ff @(posedge sysclk) begin
    if (!sys_rst_n) begin
      w  <= '0;  // Run starts at address 0
      iw <= '0;
    end else if (step) begin
      w  <= sel_addr;
      iw <= w;  // Issued address
    end
  end

  // A stalled sequencer keeps its address
  // Step comes from the credit count in the top level
  a_w_hold: assert property (
    @(posedge sysclk) disable iff (!sys_rst_n)
    !step |=> $stable(w)
  );

endmodule

/* hw/mic_return_stack.sv */
// Microcode return address stack
//   LIFO storage with entry count pointer
//   Top of stack read, zero when empty
//   Sticky overflow / underflow flag
`include "mic_macros.svh"

module mic_return_stack (
  input  logic                   sysclk,
  input  logic                   sys_rst_n,
  input  logic                   push,       // Call issued
  input  logic                   pop,        // Return issued
  input  mic_seq_pkg::mic_addr_t push_addr,  // Return address, W plus 1
  output mic_seq_pkg::mic_addr_t top,
  output logic                   stack_err   // Held until reset
);

  localparam int stack_depth = `MIC_STACK_DEPTH;
  localparam int idx_w       = $clog2(stack_depth);      // Entry index
  localparam int ptr_w       = $clog2(stack_depth + 1);  // Count 0..depth

  mic_seq_pkg::mic_addr_t mem [stack_depth];
  logic [ptr_w-1:0] sp;      // Entries held, next free slot
  logic [ptr_w-1:0] sp_dec;  // Slot of the top entry
  logic             empty;
  logic             full;

  assign empty  = (sp == '0);
  assign full   = (sp == ptr_w'(stack_depth));
  assign sp_dec = sp - 1'b1;

  // Empty stack reads as address 0
  assign top = empty ? '0 : mem[sp_dec[idx_w-1:0]];

  // Pointer and error flag
  always_ff @(posedge sysclk) begin
    if (!sys_rst_n) begin
      sp        <= '0;
      stack_err <= 1'b0;
    end else if (push) begin
      if (full) stack_err <= 1'b1;  // Overflow, entry dropped
      else      sp <= sp + 1'b1;
    end else if (pop) begin
      if (empty) stack_err <= 1'b1;  // Underflow
      else       sp <= sp_dec;
    end
  end

  // Entry write at the free slot
  always_ff @(posedge sysclk) begin
    if (push && !full) begin
      mem[sp[idx_w-1:0]] <= push_addr;
    end
  end

  // Call and return in one microword is a decode error upstream
  a_no_push_pop: assert property (
    @(posedge sysclk) disable iff (!sys_rst_n)
    !(push && pop)
  );

endmodule

/* hw/mic_control_store.sv */
// Writable control store
//   Microword memory, one word per microcode address
//   Synchronous load port
//   Asynchronous read at the working address
`include "mic_macros.svh"

module mic_control_store (
  input  logic                     sysclk,
  input  logic                     load_en,    // Program load, sequencer idle
  input  mic_seq_pkg::mic_addr_t   load_addr,
  input  mic_seq_pkg::mic_addr_t   rd_addr,    // W from the address select
  input  cs_format_pkg::mic_word_u load_word,
  output cs_format_pkg::mic_word_u rd_word
);

  // Full address space
  localparam int cs_words = 2 ** `MIC_ADDR_W;

  cs_format_pkg::mic_word_u mem [cs_words];

  // Load port
  // One word per clock while load_en is high
  always_ff @(posedge sysclk) begin
    if (load_en) begin
      mem[load_addr] <= load_word;
    end
  end

  // Read is combinational from W
  // Issue item and next address decode see it in the same cycle
  assign rd_word = mem[rd_addr];

endmodule

/* hw/mic_sequencer_top.sv */
// Microprogram sequencer top level
//   Credit counter and step generation
//   Microword decode into source, jump target, call and return
//   Issue stream to the execution consumer
//   Address select, return stack and control store instances
`include "mic_macros.svh"

module mic_sequencer_top (
  input  logic                     sysclk,
  input  logic                     sys_rst_n,
  input  logic                     run,            // Sequence from address 0
  input  logic                     load_en,
  input  mic_seq_pkg::mic_addr_t   load_addr,
  input  cs_format_pkg::mic_word_u load_word,
  input  logic [3:0]               jmp,            // Condition nibble
  input  logic                     credit_return,  // One credit per pulse
  output logic                     issue_valid,
  output mic_seq_pkg::issue_s      issue,
  output logic                     stack_err
);

  localparam int credit_w = $clog2(`MIC_CREDITS + 1);

  logic [credit_w-1:0]      credits;  // Free consumer slots
  logic                     step;
  logic                     push;
  logic                     pop;
  mic_seq_pkg::addr_src_e   src;
  mic_seq_pkg::mic_addr_t   w;
  mic_seq_pkg::mic_addr_t   next_addr;
  mic_seq_pkg::mic_addr_t   jump_addr;
  mic_seq_pkg::mic_addr_t   ret_addr;
  cs_format_pkg::mic_word_u rd_word;

  // One issue per cycle while a credit is held
  assign step = run && (credits != '0);

  // Decode, select and format are common to both views
  assign src       = rd_word.br.sel;
  assign jump_addr = {rd_word.br.jump_hi, jmp};  // Low nibble from jmp
  assign pop       = step && (src == mic_seq_pkg::src_ret);
  assign push      = step && (rd_word.br.fmt == cs_format_pkg::fmt_branch)
                     && rd_word.br.call;

  // Issue item, W and the word read at W
  assign issue_valid = step;
  assign issue.addr  = w;
  assign issue.word  = rd_word;

  // Credit counter
  // Step takes one, a returned pulse gives one back
  always_ff @(posedge sysclk) begin
    if (!sys_rst_n) credits <= credit_w'(`MIC_CREDITS);
    else            credits <= credits - credit_w'(step) + credit_w'(credit_return);
  end

  mic_addr_select u_addr_select (
    .sysclk    (sysclk),
    .sys_rst_n (sys_rst_n),
    .step      (step),
    .src       (src),
    .jump_addr (jump_addr),
    .ret_addr  (ret_addr),
    .w         (w),
    .iw        (),           // Used only inside for repeat
    .next_addr (next_addr)
  );

  mic_return_stack u_return_stack (
    .sysclk    (sysclk),
    .sys_rst_n (sys_rst_n),
    .push      (push),
    .pop       (pop),
    .push_addr (next_addr),  // Resume after the call word
    .top       (ret_addr),
    .stack_err (stack_err)
  );

  mic_control_store u_control_store (
    .sysclk    (sysclk),
    .load_en   (load_en),
    .load_addr (load_addr),
    .rd_addr   (w),
    .load_word (load_word),
    .rd_word   (rd_word)
  );

  // Consumer never returns more credits than it was given
  a_credit_max: assert property (
    @(posedge sysclk) disable iff (!sys_rst_n)
    credits <= credit_w'(`MIC_CREDITS)
  );

  // Program load only while stopped
  a_no_load_run: assert property (
    @(posedge sysclk) disable iff (!sys_rst_n)
    !(load_en && run)
  );

endmodule

/* tb/mic_checker.sv */
// Issue stream checker
//   Program model built from the load port
//   Address and microword compare against the expected trace
//   Credit accounting, run gating and stack error watch
`include "mic_macros.svh"

module mic_checker #(
  parameter int max_steps = 64
) (
  input  logic                     sysclk,
  input  logic                     sys_rst_n,
  input  logic                     run,
  input  logic                     load_en,
  input  mic_seq_pkg::mic_addr_t   load_addr,
  input  cs_format_pkg::mic_word_u load_word,
  input  logic                     credit_return,
  input  logic                     issue_valid,
  input  mic_seq_pkg::issue_s      issue,
  input  logic                     stack_err,
  input  mic_seq_pkg::mic_addr_t   exp_trace [max_steps],
  input  int                       n_steps,
  output int                       value_errs,
  output int                       protocol_errs,
  output int                       outstanding
);
  timeunit 1ns;
  timeprecision 1ps;

  logic [`MIC_WORD_W-1:0] prog [mic_seq_pkg::mic_addr_t];  // Words seen on the load port
  int   n_value    = 0;
  int   n_protocol = 0;
  int   n_issued   = 0;
  int   n_out      = 0;     // Issued, credit not yet back
  logic err_seen   = 1'b0;  // stack_err reported once

  assign value_errs    = n_value;
  assign protocol_errs = n_protocol;
  assign outstanding   = n_out;

  task automatic mismatch(input string msg);
    $display("CHECK FAILED t=%0t %s", $time, msg);
    n_value++;
  endtask

  task automatic protocol_error(input string msg);
    $display("t=%0t %s", $time, msg);
    n_protocol++;
  endtask

  always @(posedge sysclk) begin
    if (load_en) prog[load_addr] = load_word;
    if (issue_valid && !run) protocol_error("issue_valid high while run is low");
    if (!sys_rst_n) begin
      n_issued = 0;
      n_out    = 0;
    end else begin
      if (issue_valid) begin
        if (n_issued >= n_steps)
          protocol_error($sformatf("Extra issue at %h after the trace ended", issue.addr));
        else if (issue.addr !== exp_trace[n_issued])  // Order must survive stalls
          mismatch($sformatf("step %0d address %h, expected %h",
                             n_issued, issue.addr, exp_trace[n_issued]));
        if (!prog.exists(issue.addr))
          protocol_error($sformatf("Issue from address %h that was never loaded", issue.addr));
        else if (issue.word !== prog[issue.addr])
          mismatch($sformatf("step %0d word %h at %h, expected %h",
                             n_issued, issue.word, issue.addr, prog[issue.addr]));
        n_issued++;
        n_out++;
      end
      if (credit_return) n_out--;  // Consumer frees one slot
      if (n_out > `MIC_CREDITS)
        protocol_error($sformatf("%0d issues outstanding, more than the credit count", n_out));
      if (stack_err && !err_seen) begin
        err_seen = 1'b1;
        protocol_error("Return stack raised stack_err");
      end
    end
  end

endmodule

/* tb/tb_mic_top.sv */
// Testbench top for the microprogram sequencer
//   Clock, reset and program load from the pattern file
//   Run phase with one jmp nibble per issued step
//   Random credit return from a Galois LFSR
`include "mic_macros.svh"

module tb_mic_top;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int pat_words     = 384;
  localparam int load_base     = 'h000;  // Load count, then address and word pairs
  localparam int jmp_base      = 'h080;  // Step count, then one nibble per step
  localparam int trace_base    = 'h100;  // Expected address per step
  localparam int max_loads     = 60;
  localparam int max_steps     = 64;
  localparam int run_timeout   = 2000;   // Cycles for the whole trace
  localparam int drain_timeout = 200;    // Cycles for the last credits

  logic                     sysclk;
  logic                     sys_rst_n;
  logic                     run;
  logic                     load_en;
  mic_seq_pkg::mic_addr_t   load_addr;
  cs_format_pkg::mic_word_u load_word;
  logic [3:0]               jmp;
  logic                     credit_return;
  logic                     issue_valid;
  mic_seq_pkg::issue_s      issue;
  logic                     stack_err;

  logic [31:0]            pat [pat_words];  // Raw pattern file image
  logic [3:0]             jmp_tab [max_steps];
  mic_seq_pkg::mic_addr_t exp_trace [max_steps];
  int                     n_loads;
  int                     n_steps;
  int                     setup_errs;
  int                     timeouts;
  int                     value_errs;     // From the checker
  int                     protocol_errs;
  int                     outstanding;

  // Galois LFSR, x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return (s >> 1) ^ (s[0] ? 32'h8020_0003 : 32'h0);
  endfunction

  mic_sequencer_top dut (
    .sysclk        (sysclk),
    .sys_rst_n     (sys_rst_n),
    .run           (run),
    .load_en       (load_en),
    .load_addr     (load_addr),
    .load_word     (load_word),
    .jmp           (jmp),
    .credit_return (credit_return),
    .issue_valid   (issue_valid),
    .issue         (issue),
    .stack_err     (stack_err)
  );

  mic_checker #(.max_steps(max_steps)) u_checker (
    .sysclk        (dut.sysclk),
    .sys_rst_n     (dut.sys_rst_n),
    .run           (dut.run),
    .load_en       (dut.load_en),
    .load_addr     (dut.load_addr),
    .load_word     (dut.load_word),
    .credit_return (dut.credit_return),
    .issue_valid   (dut.issue_valid),
    .issue         (dut.issue),
    .stack_err     (dut.stack_err),
    .exp_trace     (exp_trace),
    .n_steps       (n_steps),
    .value_errs    (value_errs),
    .protocol_errs (protocol_errs),
    .outstanding   (outstanding)
  );

  initial begin
    sysclk = 1'b0;
    forever #4 sysclk = ~sysclk;  // 8 ns period
  end

  // Split the pattern image into program, jmp and trace tables
  task automatic read_patterns();
    $readmemh("tb/mic_patterns.txt", pat);
    n_loads = pat[load_base];
    n_steps = pat[jmp_base];
    if (n_loads > max_loads || n_steps > max_steps || n_steps == 0) begin
      $display("Pattern file holds %0d loads and %0d steps, outside the testbench limits",
               n_loads, n_steps);
      setup_errs++;
      n_loads = 0;
      n_steps = 0;
    end
    for (int i = 0; i < n_steps; i++) begin
      jmp_tab[i]   = pat[jmp_base + 1 + i][3:0];
      exp_trace[i] = pat[trace_base + i][`MIC_ADDR_W-1:0];
    end
  endtask

  // One control store word per clock
  task automatic load_program();
    for (int i = 0; i < n_loads; i++) begin
      @(posedge sysclk);
      load_en   <= 1'b1;
      load_addr <= pat[load_base + 1 + 2 * i][`MIC_ADDR_W-1:0];
      load_word <= cs_format_pkg::mic_word_u'(pat[load_base + 2 + 2 * i][`MIC_WORD_W-1:0]);
    end
    @(posedge sysclk);
    load_en <= 1'b0;
  endtask

  // Consumer model, frees one slot when the LFSR bit is set
  initial begin : credit_stim
    logic [31:0] lfsr;
    int          held;  // Issues not yet credited back
    lfsr          = 32'hdde7;
    held          = 0;
    credit_return = 1'b0;
    forever begin
      @(posedge sysclk);
      if (!sys_rst_n) begin
        held = 0;
        credit_return <= 1'b0;
      end else begin
        held = held + int'(issue_valid) - int'(credit_return);
        lfsr = lfsr_next(lfsr);  // One bit per cycle
        credit_return <= lfsr[0] && (held > 0);
      end
    end
  end

  initial begin : main_seq
    int cycles;
    int issued;
    sys_rst_n  = 1'b0;
    run        = 1'b0;
    load_en    = 1'b0;
    load_addr  = '0;
    load_word  = '0;
    jmp        = '0;
    setup_errs = 0;
    timeouts   = 0;
    read_patterns();
    repeat (16) @(posedge sysclk);
    sys_rst_n <= 1'b1;
    load_program();
    repeat (8) @(posedge sysclk);  // Idle with run low, no issue allowed
    if (setup_errs == 0) begin
      jmp <= jmp_tab[0];
      run <= 1'b1;
    end
    cycles = 0;
    issued = 0;
    while (issued < n_steps && cycles < run_timeout) begin
      @(posedge sysclk);
      cycles++;
      if (issue_valid) begin
        issued++;
        if (issued == n_steps) run <= 1'b0;  // Stop right after the last step
        else                   jmp <= jmp_tab[issued];
      end
    end
    if (issued < n_steps) begin
      $display("Timeout: only %0d of %0d steps issued in %0d cycles",
               issued, n_steps, cycles);
      timeouts++;
      run <= 1'b0;
    end
    cycles = 0;
    @(negedge sysclk);
    while (outstanding != 0 && cycles < drain_timeout) begin
      @(negedge sysclk);
      cycles++;
    end
    if (outstanding != 0) begin
      $display("Timeout: %0d credits still outstanding after run stopped", outstanding);
      timeouts++;
    end
    repeat (4) @(negedge sysclk);  // Quiet window
    $display("Errors: value %0d, protocol %0d, setup %0d, timeout %0d",
             value_errs, protocol_errs, setup_errs, timeouts);
    if (value_errs + protocol_errs + setup_errs + timeouts == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

/* tb/mic_patterns.txt */
// @000 load count, then one line per word: control store address, microword
// @080 step count, then jmp nibble per step; @100 expected issued address per step
@000
f
0000 800001  // op, next
0001 800002
0002 800003
0003 201000  // jump, high field 002
0025 800025
0026 302000  // call, high field 004
0040 800040
0041 303000  // nested call, high field 006
0063 800063
0064 400064  // return to 042
0042 400042  // return to 027
0027 204000  // jump, high field 008
008a c0008a  // repeat, back to 027
008b 80008b
008c c0008c  // repeat, back to 08b
@080
13
f f f 5 f 0 f 3 f f  // steps 0 to 9
f a f b f f f f f    // steps 10 to 18
@100
000 001 002 003 025 026 040 041 063 064
042 027 08a 027 08b 08c 08b 08c 08b

/* files.f */
+incdir+hw
hw/mic_seq_pkg.sv
hw/cs_format_pkg.sv
hw/mic_addr_select.sv
hw/mic_return_stack.sv
hw/mic_control_store.sv
hw/mic_sequencer_top.sv
tb/mic_checker.sv
tb/tb_mic_top.sv

/* Makefile */
# Verilator build and run for the microprogram sequencer testbench

VERILATOR ?= verilator
TOP       ?= tb_mic_top
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= ** PASS **

SIM_BIN := $(OBJ_DIR)/V$(TOP)
SOURCES := $(filter-out +%,$(shell cat $(FILELIST)))
HEADERS := $(wildcard hw/*.svh)

.PHONY: all run clean

all: $(SIM_BIN)

# Rebuilt only when a source, header or the file list changes
$(SIM_BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Status comes from the search for the pass line
run: $(SIM_BIN)
	@out="$$($(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qF -- '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)
